// File: Makefile
# Verilator build and run for the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= periph_subsystem.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE) -j $(JOBS)
PASS_MSG  ?= Test completed successfully

# Sources come from the file list, headers from the testbench folder
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: periph_subsystem.f
+incdir+test
verilog/periph_pkg.sv
verilog/peripheral_manager.sv
verilog/pwm_port.sv
verilog/button_counter.sv
verilog/periph_subsystem.sv
test/periph_tb.sv

// File: test/periph_tb_tasks.svh
// Testbench support for the peripheral subsystem
// Reference model state, typed compare tasks and bounded wait loops

`ifndef PERIPH_TB_TASKS_SVH
`define PERIPH_TB_TASKS_SVH

// Wait limits in clock cycles
localparam int ACK_TIMEOUT = 20;
localparam int PWM_TIMEOUT = 200;

// Model of the rising edge counts per button
word_t exp_count1;
word_t exp_count2;

// Last on and off values written to the PWM port
word_t model_on;
word_t model_off;

// Fail line, then stop the run
task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
endtask

// Read data and count values
task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        stop_on_failure();
    end
endtask

// Single bit levels such as ack and pwm_out
task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
        stop_on_failure();
    end
endtask

// Measured lengths in cycles
task automatic check_len(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        stop_on_failure();
    end
endtask

// One clock, ending on the falling edge where inputs change
task automatic step_cycle();
    @(posedge clk);
    @(negedge clk);
endtask

// Cycles until ack reaches the given level
task automatic wait_ack(input logic level, output word_t edges);
    int n;
    n = 0;
    while (ack !== level) begin
        if (n >= ACK_TIMEOUT) begin
            $display("Timeout: ack did not reach %b within %0d cycles", level, ACK_TIMEOUT);
            stop_on_failure();
        end
        step_cycle();
        n++;
    end
    edges = word_t'(n);
endtask

// Cycles until pwm_out reaches the given level, i.e. length of the current run
task automatic wait_pwm(input logic level, output word_t cycles);
    int n;
    n = 0;
    while (pwm_out !== level) begin
        if (n >= PWM_TIMEOUT) begin
            $display("Timeout: pwm_out did not reach %b within %0d cycles", level, PWM_TIMEOUT);
            stop_on_failure();
        end
        step_cycle();
        n++;
    end
    cycles = word_t'(n);
endtask

`endif

// File: test/periph_tb.sv
// Testbench for the peripheral subsystem
// Random bus traffic, button waveforms and PWM programming,
// all checked against a small model of the expected behavior

module periph_tb
    import periph_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    // Synchronizer depth used for the DUT
    localparam int SYNC_STAGES = 3;

    logic     clk;
    logic     arst_n;
    logic     req;
    bus_req_t bus_req;
    logic     ack;
    word_t    rdata;
    logic     btn1;
    logic     btn2;
    logic     pwm_out;

    integer seed = 32'h7d5b_d305;

    periph_subsystem #(
        .SYNC_STAGES (SYNC_STAGES)
    ) DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .bus_req (bus_req),
        .ack     (ack),
        .rdata   (rdata),
        .btn1    (btn1),
        .btn2    (btn2),
        .pwm_out (pwm_out)
    );

    `include "periph_tb_tasks.svh"

    // 4 ns clock
    always #2 clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    // Random offset bits around the select bit in bit 0
    function automatic addr_t make_addr(input prefix_t prefix, input logic sel);
        word_t r;
        r = $random(seed);
        return {prefix, r[28:1], sel};
    endfunction

    // One full four-phase transaction with latency checks
    task automatic bus_access(input addr_t addr, input word_t wdata, input logic we,
                              input word_t exp, input string name);
        word_t rise_edges;
        word_t fall_edges;
        int    hold;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.we    = we;
        req = 1'b1;
        wait_ack(1'b1, rise_edges);
        // One edge to sample req and two more to RESPOND
        check_len("ack rise latency", rise_edges, word_t'(3));
        if (!we) begin
            check_word(name, rdata, exp);
        end
        // Master keeps req up a while as back-pressure
        hold = rand_range(0, 5);
        for (int i = 0; i < hold; i++) begin
            step_cycle();
            check_level("ack while req held", ack, 1'b1);
            if (!we) begin
                check_word(name, rdata, exp);
            end
        end
        req = 1'b0;
        wait_ack(1'b0, fall_edges);
        // Sample edge plus one
        check_len("ack fall latency", fall_edges, word_t'(2));
    endtask

    task automatic bus_write(input addr_t addr, input word_t wdata);
        bus_access(addr, wdata, 1'b1, '0, "write");
    endtask

    task automatic read_check(input addr_t addr, input word_t exp, input string name);
        bus_access(addr, $random(seed), 1'b0, exp, name);
    endtask

    // Both counts against the model
    task automatic check_counts();
        read_check(make_addr(PREFIX_BTN, 1'b0), exp_count1, "btn1 count");
        read_check(make_addr(PREFIX_BTN, 1'b1), exp_count2, "btn2 count");
    endtask

    // Toggle each button with holds of 3 to 8 cycles and then settle
    task automatic drive_buttons(input int cycles);
        int hold1;
        int hold2;
        hold1 = rand_range(0, 5);
        hold2 = rand_range(0, 5);
        for (int i = 0; i < cycles; i++) begin
            if (hold1 == 0) begin
                btn1 = ~btn1;
                if (btn1) begin
                    exp_count1 = exp_count1 + word_t'(1);
                end
                hold1 = rand_range(3, 8);
            end
            if (hold2 == 0) begin
                btn2 = ~btn2;
                if (btn2) begin
                    exp_count2 = exp_count2 + word_t'(1);
                end
                hold2 = rand_range(3, 8);
            end
            hold1--;
            hold2--;
            step_cycle();
        end
        // Synchronizer, edge flop and counter
        repeat (SYNC_STAGES + 3) step_cycle();
    endtask

    // Write on then off and wait out the old period and one new one
    task automatic program_pwm(input word_t on_cnt, input word_t off_cnt);
        int settle;
        bus_write(make_addr(PREFIX_PWM, 1'b0), on_cnt);
        bus_write(make_addr(PREFIX_PWM, 1'b1), off_cnt);
        settle = int'(model_on + model_off + on_cnt + off_cnt) + 2;
        model_on  = on_cnt;
        model_off = off_cnt;
        repeat (settle) step_cycle();
    endtask

    // High and low run of one period starting at a rise
    task automatic check_pwm_period();
        word_t skip;
        word_t high_len;
        word_t low_len;
        wait_pwm(1'b0, skip);
        wait_pwm(1'b1, skip);
        wait_pwm(1'b0, high_len);
        wait_pwm(1'b1, low_len);
        check_len("pwm high run", high_len, model_on);
        check_len("pwm low run", low_len, model_off);
    endtask

    initial begin
        prefix_t pfx;
        logic    we;
        logic    sel;
        word_t   wdata;
        word_t   exp;
        int      highs;

        clk        = 1'b0;
        arst_n     = 1'b0;
        req        = 1'b0;
        bus_req    = '0;
        btn1       = 1'b0;
        btn2       = 1'b0;
        exp_count1 = '0;
        exp_count2 = '0;
        model_on   = '0;
        model_off  = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        step_cycle();

        // Reset state
        check_level("ack after reset", ack, 1'b0);
        check_level("pwm_out after reset", pwm_out, 1'b0);
        check_counts();

        // Random traffic over all prefixes
        for (int t = 0; t < 30; t++) begin
            pfx   = prefix_t'(rand_range(0, 7));
            we    = 1'(rand_range(0, 1));
            wdata = word_t'(rand_range(1, 20));
            sel   = 1'(rand_range(0, 1));
            exp   = '0;
            if (pfx == PREFIX_BTN) begin
                exp = sel ? exp_count2 : exp_count1;
            end
            bus_access(make_addr(pfx, sel), wdata, we, exp, "random read data");
            if (we && pfx == PREFIX_PWM) begin
                if (sel) begin
                    model_off = wdata;
                end else begin
                    model_on = wdata;
                end
            end
        end

        // Button edge counting
        for (int r = 0; r < 4; r++) begin
            drive_buttons(rand_range(30, 80));
            check_counts();
        end

        // PWM timing
        for (int r = 0; r < 4; r++) begin
            program_pwm(word_t'(rand_range(1, 20)), word_t'(rand_range(1, 20)));
            check_pwm_period();
        end

        // Unmapped, RAM and PWM reads give zero
        for (int r = 0; r < 6; r++) begin
            read_check(make_addr(PREFIX_RAM, 1'(rand_range(0, 1))), '0, "ram read");
            read_check(make_addr(PREFIX_PWM, 1'(rand_range(0, 1))), '0, "pwm read");
            read_check(make_addr(prefix_t'(rand_range(3, 7)), 1'(rand_range(0, 1))), '0,
                       "unmapped read");
        end

        // Writes outside the PWM leave timing and counts alone
        for (int r = 0; r < 6; r++) begin
            bus_write(make_addr(PREFIX_RAM, 1'(rand_range(0, 1))), $random(seed));
            bus_write(make_addr(PREFIX_BTN, 1'(rand_range(0, 1))), $random(seed));
            bus_write(make_addr(prefix_t'(rand_range(3, 7)), 1'(rand_range(0, 1))),
                      $random(seed));
        end
        check_pwm_period();
        check_counts();

        // Zero on and off keeps the output low
        program_pwm('0, '0);
        highs = 0;
        for (int i = 0; i < 60; i++) begin
            step_cycle();
            if (pwm_out !== 1'b0) begin
                highs++;
            end
        end
        check_len("pwm high cycles with zero period", word_t'(highs), '0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verilog/button_counter.sv
// Button edge counter
// Two channels, each synchronized through a flop chain and
// counting rising edges in a wrapping word counter

module button_counter
    import periph_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        btn1,
    input  logic        btn2,
    output btn_counts_t counts
);

    localparam int NUM_CH = 2;

    // Raw inputs, channel 0 is btn1
    logic [NUM_CH-1:0] btn_in;

    // Synchronizer chains, MSB is the settled level
    logic [NUM_CH-1:0][SYNC_STAGES-1:0] sync_q;

    // Previous settled level for edge detect
    logic [NUM_CH-1:0] prev_q;
    logic [NUM_CH-1:0] rise;

    word_t [NUM_CH-1:0] cnt_q;

    assign btn_in = {btn2, btn1};

    // Rising edge of the synchronized level
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            rise[ch] = sync_q[ch][SYNC_STAGES-1] && !prev_q[ch];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
            prev_q <= '0;
            cnt_q  <= '0;
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                // Shift in the asynchronous level
                sync_q[ch] <= {sync_q[ch][SYNC_STAGES-2:0], btn_in[ch]};
                prev_q[ch] <= sync_q[ch][SYNC_STAGES-1];
                // Wraps at the word limit
                if (rise[ch]) begin
                    cnt_q[ch] <= cnt_q[ch] + word_t'(1);
                end
            end
        end
    end

    assign counts.count1 = cnt_q[0];
    assign counts.count2 = cnt_q[1];

endmodule

// File: verilog/periph_pkg.sv
// Peripheral subsystem shared definitions
// Bus word types, address prefix map, request and strobe bundles
// and the bus manager state encoding

package periph_pkg;

    // Bus data word, also PWM cycle counts and button counts
    typedef logic [31:0] word_t;

    // Byte address as seen on the processor bus
    typedef logic [31:0] addr_t;

    // Peripheral select, address bits 31..29
    typedef logic [2:0] prefix_t;

    // Prefix map
    localparam prefix_t PREFIX_RAM = 3'b000;
    localparam prefix_t PREFIX_PWM = 3'b001;
    localparam prefix_t PREFIX_BTN = 3'b010;

    // One bus transaction, held stable by the master while req is high
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

    // Write strobes into the PWM port, one cycle per write
    typedef struct packed {
        logic  on_we;
        logic  off_we;
        word_t data;
    } pwm_write_t;

    // Live button edge counts
    typedef struct packed {
        word_t count1;
        word_t count2;
    } btn_counts_t;

    // Handshake FSM of the manager
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND,
        RELEASE
    } mgr_state_t;

endpackage

// File: verilog/periph_subsystem.sv
// Peripheral subsystem top
// Processor bus port into the peripheral manager, with a PWM output
// and two button edge counters behind it

module periph_subsystem
    import periph_pkg::*;
#(
    // Synchronizer depth per button, at least 2
    parameter int SYNC_STAGES = 2
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req,
    input  bus_req_t bus_req,
    output logic     ack,
    output word_t    rdata,
    input  logic     btn1,
    input  logic     btn2,
    output logic     pwm_out
);

    // Manager to PWM strobes
    pwm_write_t  pwm_wr;
    // Live counts back to the manager
    btn_counts_t btn_counts;

    // Bus handshake and decode
    peripheral_manager u_manager (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .bus_req    (bus_req),
        .ack        (ack),
        .rdata      (rdata),
        .pwm_wr     (pwm_wr),
        .btn_counts (btn_counts)
    );

    // Prefix 001
    pwm_port u_pwm (
        .clk     (clk),
        .arst_n  (arst_n),
        .pwm_wr  (pwm_wr),
        .pwm_out (pwm_out)
    );

    // Prefix 010
    button_counter #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_buttons (
        .clk    (clk),
        .arst_n (arst_n),
        .btn1   (btn1),
        .btn2   (btn2),
        .counts (btn_counts)
    );

endmodule

// File: verilog/peripheral_manager.sv
// Peripheral manager
// Runs the four-phase req/ack handshake of the processor bus,
// decodes the address prefix, pulses PWM write strobes and
// registers read data from the button counters

module peripheral_manager
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req,
    input  bus_req_t    bus_req,
    output logic        ack,
    output word_t       rdata,
    output pwm_write_t  pwm_wr,
    input  btn_counts_t btn_counts
);

    mgr_state_t state;
    mgr_state_t state_nxt;

    // Registered request line
    logic req_q;

    // Copy of the accepted transaction
    bus_req_t req_hold;

    // Decode fields of the held request
    prefix_t acc_prefix;
    logic    acc_sel;

    // Read value picked from the peripherals
    word_t rd_word;

    assign acc_prefix = req_hold.addr[31:29];
    // Offset bit 0 picks the register inside a peripheral
    assign acc_sel    = req_hold.addr[0];

    // Request line sampled once per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= 1'b0;
            state <= IDLE;
        end else begin
            req_q <= req;
            state <= state_nxt;
        end
    end

    // Handshake sequencing
    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: begin
                // Accept once req has been seen high
                if (req_q) begin
                    state_nxt = ACCESS;
                end
            end
            ACCESS: begin
                state_nxt = RESPOND;
            end
            RESPOND: begin
                // Hold ack until the master lets go
                if (!req_q) begin
                    state_nxt = RELEASE;
                end
            end
            RELEASE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Capture addr, data and we on acceptance
    always_ff @(posedge clk) begin
        if (state == IDLE && req_q) begin
            req_hold <= bus_req;
        end
    end

    // Read mux
    always_comb begin
        unique case (acc_prefix)
            PREFIX_BTN: begin
                rd_word = acc_sel ? btn_counts.count2 : btn_counts.count1;
            end
            // RAM lives elsewhere and PWM is write-only
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // Read data latched on the way into RESPOND
    always_ff @(posedge clk) begin
        if (state == ACCESS) begin
            rdata <= req_hold.we ? '0 : rd_word;
        end
    end

    // PWM strobes high for the single ACCESS cycle
    always_comb begin
        pwm_wr.on_we  = 1'b0;
        pwm_wr.off_we = 1'b0;
        pwm_wr.data   = req_hold.wdata;
        if (state == ACCESS && req_hold.we && acc_prefix == PREFIX_PWM) begin
            pwm_wr.on_we  = !acc_sel;
            pwm_wr.off_we = acc_sel;
        end
    end

    // Ack follows the response state
    assign ack = (state == RESPOND);

endmodule

// File: verilog/pwm_port.sv
// PWM port
// Programmable on and off cycle counts, written into a pending pair
// and taken over at each period boundary so pulses are never cut short

module pwm_port
    import periph_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  pwm_write_t pwm_wr,
    output logic       pwm_out
);

    // Values from the bus, not yet in use
    word_t pend_on;
    word_t pend_off;

    // Values of the running period
    word_t act_on;
    word_t act_off;

    // Cycles elapsed in the current phase
    word_t phase_cnt;
    logic  in_high;

    logic high_done;
    logic period_end;

    // Last cycle of the high phase
    assign high_done = in_high && (phase_cnt == act_on - word_t'(1));

    // Last cycle of the period, zero off skips the low phase
    assign period_end = in_high ?
                        (high_done && act_off == '0) :
                        (act_off == '0 || phase_cnt == act_off - word_t'(1));

    // Bus writes go to the pending pair
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_on  <= '0;
            pend_off <= '0;
        end else begin
            if (pwm_wr.on_we) begin
                pend_on <= pwm_wr.data;
            end
            if (pwm_wr.off_we) begin
                pend_off <= pwm_wr.data;
            end
        end
    end

    // Phase sequencing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_on    <= '0;
            act_off   <= '0;
            phase_cnt <= '0;
            in_high   <= 1'b0;
        end else if (period_end) begin
            // Reload and start a new period
            act_on    <= pend_on;
            act_off   <= pend_off;
            phase_cnt <= '0;
            // Zero on count means an all-low period
            in_high   <= (pend_on != '0);
        end else if (high_done) begin
            phase_cnt <= '0;
            in_high   <= 1'b0;
        end else begin
            phase_cnt <= phase_cnt + word_t'(1);
        end
    end

    assign pwm_out = in_high;

endmodule
